/* gps_pkg.sv */
// Shared constants and opcode bit positions for the GPS tracking channel, imported by its modules
package gps_pkg;

    //////////////////////////////////////////////////////////////////////
    // C/A code geometry

    // Chips in one C/A period
    localparam int ca_code_len = 1023;

    // Chip counter width
    // Twelve bits leave headroom above the 1023 chip period
    localparam int chip_cnt_bits = 12;

    //////////////////////////////////////////////////////////////////////
    // Correlator sizing

    // Default accumulator width
    // One epoch at four clocks per chip is 4092 samples
    // Eighteen bits keep the sum and the dither well clear of overflow
    localparam int default_integ_bits = 18;

    //////////////////////////////////////////////////////////////////////
    // Command bus

    // Bit positions within the 16-bit opcode mask
    // Several bits may be set in one write
    typedef enum logic [3:0] {
        // Satellite select from tos[10:0]
        set_sat    = 4'd0,
        // Freeze the code NCO until cg_resume
        set_pause  = 4'd1,
        // Carrier NCO rate from tos
        set_lo_nco = 4'd2,
        // Code NCO rate from tos
        set_cg_nco = 4'd3
    } cmd_bit_e;

endpackage

/* ca_code_gen.sv */
// C/A Gold-code generator for one satellite, stepped by the code tracker once per chip
`timescale 1ns/100ps

module ca_code_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        g2_init,
    input  logic [10:1] init,
    input  logic        rd,
    output logic        chip
);

    // G1 and G2 shift registers
    logic [10:1] g1;
    logic [10:1] g2;

    // Feedback taps
    logic        g1_fb;
    logic        g2_fb;

    // G1 is one step from its all-ones start state
    logic        g1_wrap;

    // Selected G2 output
    logic        g2_out;

    // G1 taps 3 and 10
    assign g1_fb = g1[3] ^ g1[10];

    // G2 taps 2, 3, 6, 8, 9 and 10
    assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

    // Next G1 state is all ones only from 0111111111
    assign g1_wrap = (g1 == 10'b01_1111_1111);

    // Preset mode takes the last stage
    // Otherwise init marks the two phase-select taps
    assign g2_out = g2_init ? g2[10] : ^(g2 & init);

    assign chip = g1[10] ^ g2_out;

    //////////////////////////////////////////////////////////////////////
    // Register stepping

    always_ff @(posedge clk) begin
        if (rst) begin
            g1 <= '1;
            g2 <= g2_init ? init : '1;
        end else if (rd) begin
            g1 <= {g1[9:1], g1_fb};
            // Preset mode reloads G2 in step with the G1 period
            if (g2_init && g1_wrap) begin
                g2 <= init;
            end else begin
                g2 <= {g2[9:1], g2_fb};
            end
        end
    end

endmodule

/* gps_nco.sv */
// Carrier and code NCOs of the channel, giving quadrature LO bits and chip-rate strobes
`timescale 1ns/100ps

module gps_nco (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] lo_rate,
    input  logic [31:0] cg_rate,
    input  logic        pause_cmd,
    input  logic        cg_resume,
    output logic        lo_i,
    output logic        lo_q,
    output logic        quarter_chip,
    output logic        half_chip,
    output logic        full_chip,
    output logic        chip_en
);

    // Quadrature sign patterns indexed by the top two phase bits
    localparam logic [3:0] lo_sin = 4'b1100;
    localparam logic [3:0] lo_cos = 4'b0110;

    logic [31:0] lo_phase;
    logic [31:0] cg_phase;
    logic        cg_en;

    // Partial sums exposing the carries out of bits 29, 30 and 31
    logic [30:0] sum_q;
    logic [31:0] sum_h;
    logic [32:0] sum_f;

    //////////////////////////////////////////////////////////////////////
    // Carrier NCO

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_phase <= '0;
        end else begin
            lo_phase <= lo_phase + lo_rate;
        end
    end

    assign lo_i = lo_sin[lo_phase[31:30]];
    assign lo_q = lo_cos[lo_phase[31:30]];

    //////////////////////////////////////////////////////////////////////
    // Code NCO

    assign sum_q = {1'b0, cg_phase[29:0]} + {1'b0, cg_rate[29:0]};
    assign sum_h = {1'b0, cg_phase[30:0]} + {1'b0, cg_rate[30:0]};
    assign sum_f = {1'b0, cg_phase} + {1'b0, cg_rate};

    // Sub-chip strobes exist only on cycles that really add
    // A frozen phase would otherwise repeat the same carry every clock
    assign quarter_chip = sum_q[30] & cg_en;
    assign half_chip    = sum_h[31] & cg_en;
    assign full_chip    = sum_f[32];
    assign chip_en      = full_chip & cg_en;

    // Pause wins over a resume in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cg_en <= 1'b0;
        end else if (pause_cmd) begin
            cg_en <= 1'b0;
        end else if (!cg_en) begin
            cg_en <= cg_resume;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cg_phase <= '0;
        end else if (cg_en) begin
            cg_phase <= sum_f[31:0];
        end
    end

endmodule

/* code_tracker.sv */
// Chip counter and early/prompt/late code taps of the channel, with the epoch and dump flags
`timescale 1ns/100ps

module code_tracker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             chip_en,
    input  logic                             quarter_chip,
    input  logic                             half_chip,
    input  logic                             full_chip,
    input  logic                             ca_chip,
    output logic                             ca_rd,
    output logic [gps_pkg::chip_cnt_bits-1:0] nchip,
    output logic                             chip_e,
    output logic                             chip_p,
    output logic                             chip_l,
    output logic                             epoch,
    output logic                             epoch_dump
);

    import gps_pkg::*;

    // Last chip index of the period
    localparam logic [chip_cnt_bits-1:0] last_chip = chip_cnt_bits'(ca_code_len - 1);

    // Mid-chip strobe is a half carry without a full carry
    logic mid_chip;
    // Chip boundary carries both
    logic edge_chip;

    assign mid_chip  = half_chip & ~full_chip;
    assign edge_chip = half_chip & full_chip;

    // Generator steps together with the chip counter
    assign ca_rd = chip_en;

    // Generator output leads the other taps
    assign chip_e = ca_chip;

    //////////////////////////////////////////////////////////////////////
    // Chip count and taps

    always_ff @(posedge clk) begin
        if (rst) begin
            nchip      <= '0;
            chip_p     <= 1'b0;
            chip_l     <= 1'b0;
            epoch      <= 1'b0;
            epoch_dump <= 1'b0;
        end else begin
            if (chip_en) begin
                nchip <= (nchip == last_chip) ? '0 : nchip + 1'b1;
            end

            // Prompt lags early by half a chip
            // Epoch marks the middle of chip 0
            if (mid_chip) begin
                chip_p <= chip_e;
                epoch  <= (nchip == '0);
            end else begin
                epoch  <= 1'b0;
            end

            // Late lags prompt by another half chip
            if (edge_chip) begin
                chip_l <= chip_p;
            end

            epoch_dump <= epoch;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_nchip_range: assert property (@(posedge clk) disable iff (rst) nchip <= last_chip)
        else $error("code_tracker: nchip out of range %h", nchip);

    a_epoch_pulse: assert property (@(posedge clk) disable iff (rst) epoch |=> !epoch)
        else $error("code_tracker: epoch longer than one clock");

endmodule

/* iq_correlator.sv */
// Carrier and code mixers with six integrate-and-dump accumulators and their serial readout
`timescale 1ns/100ps

module iq_correlator #(
    parameter int integ_bits = gps_pkg::default_integ_bits
) (
    input  logic clk,
    input  logic rst,
    input  logic sample,
    input  logic lo_i,
    input  logic lo_q,
    input  logic chip_e,
    input  logic chip_p,
    input  logic chip_l,
    input  logic epoch_dump,
    input  logic shift,
    output logic sout
);

    localparam int ser_bits = 6 * integ_bits;

    // Channel order ip, qp, ie, qe, il, ql
    logic [5:0]            code_tap;
    logic [5:0]            lo_tap;
    logic [5:0]            mix;
    logic [integ_bits-1:0] acc [6];
    logic                  lsb;
    logic [ser_bits-1:0]   ser_iq;

    assign code_tap = {chip_p, chip_p, chip_e, chip_e, chip_l, chip_l};
    assign lo_tap   = {lo_i, lo_q, lo_i, lo_q, lo_i, lo_q};

    //////////////////////////////////////////////////////////////////////
    // Mixers and accumulators

    always_ff @(posedge clk) begin
        if (rst) begin
            mix <= '0;
            lsb <= 1'b0;
            for (int k = 0; k < 6; k++) begin
                acc[k] <= '0;
            end
        end else begin
            mix <= {6{sample}} ^ code_tap ^ lo_tap;
            // Dither bit restarts with each dump
            lsb <= epoch_dump ? 1'b0 : ~lsb;
            for (int k = 0; k < 6; k++) begin
                // A set mixer bit counts minus one
                acc[k] <= (epoch_dump ? '0 : acc[k]) + {integ_bits{mix[5-k]}}
                          + integ_bits'(lsb);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Serial readout

    always_ff @(posedge clk) begin
        if (rst) begin
            ser_iq <= '0;
        end else if (epoch_dump) begin
            ser_iq <= {acc[0], acc[1], acc[2], acc[3], acc[4], acc[5]};
        end else if (shift) begin
            ser_iq <= ser_iq << 1;
        end
    end

    assign sout = ser_iq[ser_bits-1];

    a_no_shift_on_dump: assert property (@(posedge clk) disable iff (rst)
        !(shift && epoch_dump))
        else $error("iq_correlator: shift during dump");

endmodule

/* channel_ctrl.sv */
// Command decoder of the channel, holding satellite selection and NCO rates written by the CPU
`timescale 1ns/100ps

module channel_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_reg,
    input  logic [15:0] op,
    input  logic [31:0] tos,
    output logic [31:0] lo_rate,
    output logic [31:0] cg_rate,
    output logic        g2_init,
    output logic [10:1] init,
    output logic        pause_cmd
);

    import gps_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Register writes

    // Each opcode bit is decoded on its own
    always_ff @(posedge clk) begin
        if (rst) begin
            lo_rate <= '0;
            cg_rate <= '0;
            g2_init <= 1'b0;
            init    <= '0;
        end else if (wr_reg) begin
            if (op[set_sat]) begin
                // G2 preset flag above the ten select bits
                g2_init <= tos[10];
                init    <= tos[9:0];
            end
            if (op[set_lo_nco]) begin
                lo_rate <= tos;
            end
            if (op[set_cg_nco]) begin
                cg_rate <= tos;
            end
        end
    end

    // Pause acts on the code NCO at the next edge
    assign pause_cmd = wr_reg & op[set_pause];

    // A write always carries at least one opcode bit
    a_op_nonzero: assert property (@(posedge clk) disable iff (rst) wr_reg |-> (op != '0))
        else $error("channel_ctrl: write with empty opcode");

endmodule

/* gps_channel.sv */
// Top level of one GPS L1 C/A tracking channel, driven by the CPU command bus
`timescale 1ns/100ps

module gps_channel #(
    parameter int integ_bits = gps_pkg::default_integ_bits
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sample,
    input  logic                              cg_resume,
    input  logic                              wr_reg,
    input  logic [15:0]                       op,
    input  logic [31:0]                       tos,
    input  logic                              shift,
    output logic [gps_pkg::chip_cnt_bits-1:0] nchip,
    output logic                              sout,
    output logic                              epoch
);

    // Control outputs
    logic [31:0] lo_rate;
    logic [31:0] cg_rate;
    logic        g2_init;
    logic [10:1] init;
    logic        pause_cmd;

    // NCO outputs
    logic        lo_i;
    logic        lo_q;
    logic        quarter_chip;
    logic        half_chip;
    logic        full_chip;
    logic        chip_en;

    // Code taps
    logic        ca_rd;
    logic        ca_chip;
    logic        chip_e;
    logic        chip_p;
    logic        chip_l;
    logic        epoch_dump;

    channel_ctrl i_channel_ctrl (
        .clk, .rst, .wr_reg, .op, .tos,
        .lo_rate, .cg_rate, .g2_init, .init, .pause_cmd
    );

    gps_nco i_gps_nco (
        .clk, .rst, .lo_rate, .cg_rate, .pause_cmd, .cg_resume,
        .lo_i, .lo_q, .quarter_chip, .half_chip, .full_chip, .chip_en
    );

    ca_code_gen i_ca_code_gen (
        .clk, .rst, .g2_init, .init, .rd(ca_rd), .chip(ca_chip)
    );

    code_tracker i_code_tracker (
        .clk, .rst, .chip_en, .quarter_chip, .half_chip, .full_chip, .ca_chip,
        .ca_rd, .nchip, .chip_e, .chip_p, .chip_l, .epoch, .epoch_dump
    );

    iq_correlator #(
        .integ_bits(integ_bits)
    ) i_iq_correlator (
        .clk, .rst, .sample, .lo_i, .lo_q, .chip_e, .chip_p, .chip_l,
        .epoch_dump, .shift, .sout
    );

endmodule

/* tb_gps_channel.sv */
// Directed testbench for the GPS tracking channel, compiled from compile.f with this module as top
`timescale 1ns/100ps

module tb_gps_channel;

    import gps_pkg::*;

    localparam int integ_bits = 18;
    localparam int code_len   = 1023;
    // Four clocks per chip at a code rate of 2^30
    localparam int epoch_clks = 4 * code_len;
    // Epoch budget covers chip counting twice plus correlation, drain, noise and setup
    localparam int watchdog_clks = 6 * epoch_clks + 2000;
    // Ninety percent of a half epoch, rounded up
    localparam int corr_min = (9 * epoch_clks / 2 + 9) / 10;

    logic clk, rst, sample, cg_resume, wr_reg, shift, sout, epoch;
    logic [15:0] op;
    logic [31:0] tos;
    logic [11:0] nchip;

    // C/A model registers for PRN 1
    logic [10:1] g1, g2;
    logic [31:0] lfsr;
    // Clocks since the code NCO started
    int cyc;
    // Sample source is 0 for idle, 1 for the model chip and 2 for noise
    int mode;
    logic [integ_bits-1:0] iq [6];
    string iq_name [6] = '{"ip", "qp", "ie", "qe", "il", "ql"};

    gps_channel #(.integ_bits(integ_bits)) i_gps_channel (
        .clk, .rst, .sample, .cg_resume, .wr_reg, .op, .tos, .shift, .nchip, .sout, .epoch
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_clks * 10);
        $display("Watchdog expired after %0d clocks", watchdog_clks);
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int mag(logic [integ_bits-1:0] w);
        logic signed [integ_bits-1:0] s;
        int v;
        s = w;
        v = s;
        return (v < 0) ? -v : v;
    endfunction

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] expv);
        assert (got === expv) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expv);
            abort_run();
        end
    endtask

    task automatic check_mag(string name, logic [integ_bits-1:0] w, int lo, int hi);
        assert (mag(w) >= lo && mag(w) < hi) else begin
            $display("FAILED %s: magnitude %h outside %h to %h", name, mag(w), lo, hi);
            abort_run();
        end
    endtask

    // One clock, then fresh stimulus 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
        cyc++;
        // Prompt holds chip n over clocks 4n+2 to 4n+5
        if (cyc >= 6 && cyc % 4 == 2) begin
            g1 = {g1[9:1], g1[3] ^ g1[10]};
            g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
        end
        case (mode)
            1: sample = g1[10] ^ g2[2] ^ g2[6];
            2: begin
                lfsr   = lfsr_step(lfsr);
                sample = lfsr[0];
            end
            default: sample = 1'b0;
        endcase
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (3) tick();
        rst = 1'b0;
    endtask

    task automatic write_cmd(logic [15:0] mask, logic [31:0] data);
        wr_reg = 1'b1;
        op     = mask;
        tos    = data;
        tick();
        wr_reg = 1'b0;
        op     = '0;
        tos    = '0;
    endtask

    task automatic resume();
        cg_resume = 1'b1;
        tick();
        cg_resume = 1'b0;
    endtask

    // Leaves the run in the dump cycle that follows the epoch
    task automatic wait_epoch();
        int n;
        n = 0;
        while (!epoch && n < epoch_clks + 16) begin
            tick();
            n++;
        end
        assert (epoch) else begin
            $display("No epoch within %0d clocks", n);
            abort_run();
        end
        tick();
    endtask

    // Words leave MSB first in the order ip, qp, ie, qe, il, ql
    task automatic read_iq();
        for (int w = 0; w < 6; w++) begin
            for (int b = 0; b < integ_bits; b++) begin
                iq[w] = {iq[w][integ_bits-2:0], sout};
                shift = 1'b1;
                tick();
            end
        end
        shift = 1'b0;
    endtask

    task automatic start_channel();
        reset_dut();
        // PRN 1 picks G2 taps 2 and 6 through tos[1] and tos[5]
        write_cmd(16'(1) << set_sat, 32'h0000_0022);
        write_cmd(16'(1) << set_lo_nco, 32'h0);
        write_cmd(16'(1) << set_cg_nco, 32'h4000_0000);
        g1  = '1;
        g2  = '1;
        cyc = -1;
        resume();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset();
        reset_dut();
        check_eq("epoch", epoch, 0);
        check_eq("nchip", nchip, 0);
        check_eq("sout", sout, 0);
        // Code NCO stays paused without a resume even with a rate set
        write_cmd(16'(1) << set_cg_nco, 32'h4000_0000);
        repeat (100) begin
            tick();
            check_eq("nchip", nchip, 0);
        end
    endtask

    task automatic test_chip_count();
        int last;
        last = -1;
        start_channel();
        while (cyc < 2 * epoch_clks + 8) begin
            check_eq("nchip", nchip, (cyc / 4) % code_len);
            // Epoch follows the mid-chip strobe of chip 0
            check_eq("epoch", epoch, cyc % epoch_clks == 2);
            if (epoch && last >= 0) begin
                check_eq("epoch spacing", cyc - last, epoch_clks);
            end
            if (epoch) begin
                last = cyc;
            end
            tick();
        end
    endtask

    task automatic test_pause();
        int held;
        start_channel();
        while (cyc < 401) begin
            tick();
        end
        // 402 enabled clocks make 100 full chips
        write_cmd(16'(1) << set_pause, 32'h0);
        held = nchip;
        check_eq("nchip", held, 100);
        repeat (200) begin
            tick();
            check_eq("nchip", nchip, held);
        end
        resume();
        repeat (8) begin
            if (nchip == held) begin
                tick();
            end
        end
        check_eq("nchip", nchip, held + 1);
    endtask

    task automatic test_correlation();
        mode = 1;
        start_channel();
        // First dump opens a clean period and the second closes it
        wait_epoch();
        wait_epoch();
        tick();
        read_iq();
        check_mag("ip", iq[0], corr_min, epoch_clks);
        check_mag("qp", iq[1], corr_min, epoch_clks);
        check_mag("ie", iq[2], 0, mag(iq[0]));
        check_mag("il", iq[4], 0, mag(iq[0]));
    endtask

    task automatic test_drain();
        shift = 1'b1;
        repeat (200) begin
            check_eq("sout", sout, 0);
            tick();
        end
        shift = 1'b0;
        // Next dump refills the register
        wait_epoch();
        tick();
        read_iq();
        check_mag("ip", iq[0], corr_min, epoch_clks);
    endtask

    task automatic test_noise();
        mode = 2;
        start_channel();
        wait_epoch();
        wait_epoch();
        tick();
        read_iq();
        for (int k = 0; k < 6; k++) begin
            check_mag(iq_name[k], iq[k], 0, epoch_clks / 4);
        end
    endtask

    initial begin
        rst       = 1'b1;
        sample    = 1'b0;
        cg_resume = 1'b0;
        wr_reg    = 1'b0;
        op        = '0;
        tos       = '0;
        shift     = 1'b0;
        mode      = 0;
        cyc       = 0;
        lfsr      = 32'h279d;
        g1        = '1;
        g2        = '1;
        test_reset();
        test_chip_count();
        test_pause();
        test_correlation();
        test_drain();
        test_noise();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* compile.f */
gps_pkg.sv
ca_code_gen.sv
gps_nco.sv
code_tracker.sv
iq_correlator.sv
channel_ctrl.sv
gps_channel.sv
tb_gps_channel.sv

/* Bender.yml */
package:
  name: gps_channel

sources:
  - gps_pkg.sv
  - ca_code_gen.sv
  - gps_nco.sv
  - code_tracker.sv
  - iq_correlator.sv
  - channel_ctrl.sv
  - gps_channel.sv
  - target: test
    files:
      - tb_gps_channel.sv
